//--- f2_board.f
f2_pkg.sv
f2_addr_decode.sv
f2_cpu_bus.sv
f2_work_ram.sv
f2_palette.sv
f2_input_ports.sv
f2_interrupts.sv
f2_board.sv
f2_board_tb.sv

//--- Bender.yml
package:
  name: f2_board

sources:
  - f2_pkg.sv
  - f2_addr_decode.sv
  - f2_cpu_bus.sv
  - f2_work_ram.sv
  - f2_palette.sv
  - f2_input_ports.sv
  - f2_interrupts.sv
  - f2_board.sv
  - target: test
    files:
      - f2_board_tb.sv

//--- f2_board_tb.sv
`timescale 1ns/1ps

module f2_board_tb import f2_pkg::*; ();

    localparam int         MAX_CYCLES = 20000;
    localparam int         WORK_POOL  = 40;
    localparam int         COLOR_POOL = 48;
    localparam int         PIXELS     = 64;
    localparam logic [2:0] FC_DATA    = 3'b101;

    logic                clk;
    logic                reset;
    logic                as_n;
    logic [1:0]          ds_n;
    logic                rw;
    logic [2:0]          fc;
    word_addr_t          addr;
    bus_data_t           wdata;
    bus_data_t           rdata;
    logic                dtack_n;
    logic [2:0]          ipl_n;
    logic [7:0]          joystick_p1;
    logic [7:0]          joystick_p2;
    logic [1:0]          start;
    logic [1:0]          coin;
    logic [7:0]          dswa;
    logic [7:0]          dswb;
    logic                vblank_n;
    logic                dma_done;
    logic [COLOR_AW-1:0] pixel_index;
    rgb_t                rgb;

    bus_data_t           work_ref   [2**WORK_AW];
    bus_data_t           color_ref  [2**COLOR_AW];
    logic [WORK_AW-1:0]  work_pool  [WORK_POOL];
    logic [COLOR_AW-1:0] color_pool [COLOR_POOL];
    logic [31:0]         rand_state;
    int                  cycles;
    int                  value_errors;
    int                  handshake_errors;

    // Pending comparisons, filled by the stimulus
    logic [31:0]         got_q  [$];
    logic [31:0]         exp_q  [$];
    string               what_q [$];
    event                check_ev;

    f2_board uut (
        .clk         (clk),
        .reset       (reset),
        .as_n        (as_n),
        .ds_n        (ds_n),
        .rw          (rw),
        .fc          (fc),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .dtack_n     (dtack_n),
        .ipl_n       (ipl_n),
        .joystick_p1 (joystick_p1),
        .joystick_p2 (joystick_p2),
        .start       (start),
        .coin        (coin),
        .dswa        (dswa),
        .dswb        (dswb),
        .vblank_n    (vblank_n),
        .dma_done    (dma_done),
        .pixel_index (pixel_index),
        .rgb         (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout, the run did not finish within %0d clocks", MAX_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rand_state = xorshift(rand_state);
        return rand_state;
    endfunction

    // Start on top, then joystick 6..4, then joystick 0..3 reversed
    function automatic logic [7:0] player_byte(input logic st, input logic [7:0] joy);
        logic [7:0] b;
        b[7]   = st;
        b[6:4] = joy[6:4];
        for (int i = 0; i < 4; i++) begin
            b[3-i] = joy[i];
        end
        return b;
    endfunction

    function automatic logic [7:0] expected_input_byte(input int idx);
        logic [7:0] raw;
        case (idx)
            0:       raw = dswa;
            1:       raw = dswb;
            2:       raw = player_byte(start[0], joystick_p1);
            3:       raw = player_byte(start[1], joystick_p2);
            4:       raw = {4'b0000, coin, 2'b00};
            default: raw = 8'h00;
        endcase
        return ~raw;
    endfunction

    function automatic logic [23:0] expected_rgb(input bus_data_t color);
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
        r = color[4:0];
        g = color[9:5];
        b = color[14:10];
        return {r, r[4:2], g, g[4:2], b, b[4:2]};
    endfunction

    function automatic logic [2:0] expected_ipl(input logic vbl, input logic dma);
        if (dma) begin
            return ~DMA_LEVEL;
        end else if (vbl) begin
            return ~VBL_LEVEL;
        end
        return 3'b111;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Comparing process

    initial begin
        logic [31:0] got_v;
        logic [31:0] exp_v;
        string       what_v;
        forever begin
            @(check_ev);
            while (got_q.size() != 0) begin
                got_v  = got_q.pop_front();
                exp_v  = exp_q.pop_front();
                what_v = what_q.pop_front();
                if (got_v !== exp_v) begin
                    $display("Fail at %0d ns: %s, got %h, expected %h",
                             $time, what_v, got_v, exp_v);
                    value_errors++;
                end
            end
        end
    end

    task automatic expect_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        what_q.push_back(what);
        exp_q.push_back(exp);
        got_q.push_back(got);
        -> check_ev;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus driver

    // Inputs change 2 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic bus_cycle(input logic is_read, input logic [2:0] code, input word_addr_t a,
                             input logic [1:0] lanes, input bus_data_t wd,
                             output bus_data_t q);
        int waited;
        int extra;
        as_n   = 1'b0;
        ds_n   = lanes;
        rw     = is_read;
        fc     = code;
        addr   = a;
        wdata  = wd;
        q      = '0;
        waited = 0;
        // Start edge plus two more
        do begin
            tick();
            waited++;
        end while (dtack_n !== 1'b0 && waited < 8);
        if (dtack_n !== 1'b0) begin
            $display("DTACK never came for the bus cycle at address %h", a);
            handshake_errors++;
        end else begin
            expect_value("edges from drive to dtack_n low", waited, 3);
            q     = rdata;
            extra = next_rand() % 6;
            repeat (extra) begin
                tick();
                expect_value("dtack_n while as_n held low", dtack_n, 0);
            end
        end
        as_n = 1'b1;
        ds_n = 2'b11;
        rw   = 1'b1;
        tick();
        expect_value("dtack_n after as_n rises", dtack_n, 1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests

    task automatic work_ram_test();
        logic [31:0]        r;
        logic [WORK_AW-1:0] off;
        logic [1:0]         lanes;
        bus_data_t          data;
        bus_data_t          q;
        for (int i = 0; i < WORK_POOL; i++) begin
            work_pool[i] = next_rand();
            data         = next_rand();
            bus_cycle(1'b0, FC_DATA, WORK_BASE[23:1] + work_pool[i], 2'b00, data, q);
            work_ref[work_pool[i]] = data;
        end
        for (int i = 0; i < 200; i++) begin
            r     = next_rand();
            off   = work_pool[r % WORK_POOL];
            lanes = (r[17:16] == 2'd0) ? 2'b00 : (r[17:16] == 2'd1) ? 2'b01 : 2'b10;
            data  = next_rand();
            bus_cycle(1'b0, FC_DATA, WORK_BASE[23:1] + off, lanes, data, q);
            if (!lanes[1]) begin
                work_ref[off][15:8] = data[15:8];
            end
            if (!lanes[0]) begin
                work_ref[off][7:0] = data[7:0];
            end
        end
        for (int i = 0; i < WORK_POOL; i++) begin
            bus_cycle(1'b1, FC_DATA, WORK_BASE[23:1] + work_pool[i], 2'b00, '0, q);
            expect_value($sformatf("work RAM word %h", work_pool[i]), q, work_ref[work_pool[i]]);
        end
    endtask

    task automatic color_test();
        logic [COLOR_AW-1:0] pix_seq [PIXELS];
        bus_data_t           data;
        bus_data_t           q;
        for (int i = 0; i < COLOR_POOL; i++) begin
            color_pool[i] = next_rand();
            data          = next_rand();
            bus_cycle(1'b0, FC_DATA, COLOR_BASE[23:1] + color_pool[i], 2'b00, data, q);
            color_ref[color_pool[i]] = data;
        end
        for (int i = 0; i < COLOR_POOL; i++) begin
            bus_cycle(1'b1, FC_DATA, COLOR_BASE[23:1] + color_pool[i], 2'b00, '0, q);
            expect_value("colour RAM readback", q, color_ref[color_pool[i]]);
        end
        for (int i = 0; i < PIXELS; i++) begin
            pix_seq[i] = color_pool[next_rand() % COLOR_POOL];
        end
        // New index every clock
        for (int j = 0; j < PIXELS + 2; j++) begin
            if (j < PIXELS) begin
                pixel_index = pix_seq[j];
            end
            if (j >= 2) begin
                expect_value("rgb two clocks after pixel_index", {8'h00, rgb},
                             expected_rgb(color_ref[pix_seq[j-2]]));
            end
            tick();
        end
    endtask

    task automatic input_test();
        logic [31:0] r;
        bus_data_t   q;
        for (int round = 0; round < 4; round++) begin
            r           = next_rand();
            joystick_p1 = r[7:0];
            joystick_p2 = r[15:8];
            start       = r[17:16];
            coin        = r[19:18];
            dswa        = r[27:20];
            r           = next_rand();
            dswb        = r[7:0];
            repeat (5) tick();
            for (int idx = 0; idx < 8; idx++) begin
                bus_cycle(1'b1, FC_DATA, IO_BASE[23:1] + idx, 2'b00, '0, q);
                expect_value($sformatf("input port %0d", idx), q,
                             {8'h00, expected_input_byte(idx)});
            end
        end
    endtask

    task automatic interrupt_test();
        bus_data_t q;
        expect_value("ipl_n with nothing pending", ipl_n, expected_ipl(1'b0, 1'b0));
        vblank_n = 1'b0;
        tick();
        tick();
        expect_value("ipl_n after vblank edge", ipl_n, expected_ipl(1'b1, 1'b0));
        vblank_n = 1'b1;
        dma_done = 1'b1;
        tick();
        tick();
        expect_value("ipl_n after dma edge", ipl_n, expected_ipl(1'b1, 1'b1));
        dma_done = 1'b0;
        bus_cycle(1'b1, FC_IACK, {20'hFFFFF, DMA_LEVEL}, 2'b00, '0, q);
        expect_value("IACK read data", q, 0);
        expect_value("ipl_n after level 6 IACK", ipl_n, expected_ipl(1'b1, 1'b0));
        bus_cycle(1'b1, FC_IACK, {20'hFFFFF, VBL_LEVEL}, 2'b00, '0, q);
        expect_value("ipl_n after level 5 IACK", ipl_n, expected_ipl(1'b0, 1'b0));
    endtask

    // Low address bits alias both RAMs, so these writes would show up there
    task automatic unmapped_test();
        bus_data_t q;
        bus_cycle(1'b1, FC_DATA, 23'h200000 | work_pool[1], 2'b00, '0, q);
        expect_value("unmapped read", q, 0);
        bus_cycle(1'b0, FC_DATA, 23'h200000 | work_pool[0], 2'b00, ~work_ref[work_pool[0]], q);
        bus_cycle(1'b0, FC_DATA, 23'h200000 | color_pool[0], 2'b00, 16'h5A5A, q);
        bus_cycle(1'b1, FC_DATA, WORK_BASE[23:1] + work_pool[0], 2'b00, '0, q);
        expect_value("work RAM after unmapped write", q, work_ref[work_pool[0]]);
        bus_cycle(1'b1, FC_DATA, COLOR_BASE[23:1] + color_pool[0], 2'b00, '0, q);
        expect_value("colour RAM after unmapped write", q, color_ref[color_pool[0]]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        rand_state       = 32'hea8c;
        value_errors     = 0;
        handshake_errors = 0;
        reset            = 1'b1;
        as_n             = 1'b1;
        ds_n             = 2'b11;
        rw               = 1'b1;
        fc               = FC_DATA;
        addr             = '0;
        wdata            = '0;
        joystick_p1      = '0;
        joystick_p2      = '0;
        start            = '0;
        coin             = '0;
        dswa             = '0;
        dswb             = '0;
        vblank_n         = 1'b1;
        dma_done         = 1'b0;
        pixel_index      = '0;

        repeat (10) @(posedge clk);
        #2;
        expect_value("dtack_n in reset", dtack_n, 1);
        expect_value("rdata in reset", rdata, 0);
        expect_value("ipl_n in reset", ipl_n, 3'b111);
        reset = 1'b0;
        tick();

        work_ram_test();
        color_test();
        input_test();
        interrupt_test();
        unmapped_test();

        tick();
        $display("Value errors: %0d, handshake errors: %0d", value_errors, handshake_errors);
        if (value_errors == 0 && handshake_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- f2_board.sv
`timescale 1ns/1ps

module f2_board import f2_pkg::*; (
    input  logic                clk,
    input  logic                reset,

    // CPU bus
    input  logic                as_n,
    input  logic [1:0]          ds_n,
    input  logic                rw,
    input  logic [2:0]          fc,
    input  word_addr_t          addr,
    input  bus_data_t           wdata,
    output bus_data_t           rdata,
    output logic                dtack_n,
    output logic [2:0]          ipl_n,

    // Player controls
    input  logic [7:0]          joystick_p1,
    input  logic [7:0]          joystick_p2,
    input  logic [1:0]          start,
    input  logic [1:0]          coin,
    input  logic [7:0]          dswa,
    input  logic [7:0]          dswb,

    // Video
    input  logic                vblank_n,
    input  logic                dma_done,
    input  logic [COLOR_AW-1:0] pixel_index,
    output rgb_t                rgb
);

    bus_region_t region;

    logic      work_access;
    logic      color_access;
    logic      io_access;
    logic      iack_access;

    bus_data_t work_q;
    bus_data_t color_q;
    bus_data_t io_q;

    ////////////////////////////////////////////////////////////////////////////
    // Bus control

    f2_addr_decode u_addr_decode (
        .addr   (addr),
        .fc     (fc),
        .region (region)
    );

    f2_cpu_bus u_cpu_bus (
        .clk          (clk),
        .reset        (reset),
        .as_n         (as_n),
        .ds_n         (ds_n),
        .region       (region),
        .work_q       (work_q),
        .color_q      (color_q),
        .io_q         (io_q),
        .work_access  (work_access),
        .color_access (color_access),
        .io_access    (io_access),
        .iack_access  (iack_access),
        .rdata        (rdata),
        .dtack_n      (dtack_n)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Targets

    f2_work_ram #(
        .ADDR_W_RAM (WORK_AW)
    ) u_work_ram (
        .clk    (clk),
        .access (work_access),
        .rw     (rw),
        .ds_n   (ds_n),
        .addr   (addr[WORK_AW-1:0]),
        .wdata  (wdata),
        .q      (work_q)
    );

    f2_palette u_palette (
        .clk         (clk),
        .access      (color_access),
        .rw          (rw),
        .ds_n        (ds_n),
        .addr        (addr[COLOR_AW-1:0]),
        .wdata       (wdata),
        .q           (color_q),
        .pixel_index (pixel_index),
        .rgb         (rgb)
    );

    f2_input_ports u_input_ports (
        .clk         (clk),
        .reset       (reset),
        .access      (io_access),
        .addr        (addr[IO_AW-1:0]),
        .joystick_p1 (joystick_p1),
        .joystick_p2 (joystick_p2),
        .start       (start),
        .coin        (coin),
        .dswa        (dswa),
        .dswb        (dswb),
        .q           (io_q)
    );

    f2_interrupts u_interrupts (
        .clk         (clk),
        .reset       (reset),
        .vblank_n    (vblank_n),
        .dma_done    (dma_done),
        .iack_access (iack_access),
        .addr        (addr[2:0]),
        .ipl_n       (ipl_n)
    );

endmodule

//--- f2_interrupts.sv
`timescale 1ns/1ps

module f2_interrupts import f2_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  logic       vblank_n,
    input  logic       dma_done,

    input  logic       iack_access,
    input  logic [2:0] addr,

    output logic [2:0] ipl_n
);

    logic vbl_prev;
    logic dma_prev;
    logic vbl_pending;
    logic dma_pending;
    logic vbl_edge;
    logic dma_edge;

    assign vbl_edge = vbl_prev && !vblank_n;
    assign dma_edge = !dma_prev && dma_done;

    always_ff @(posedge clk) begin
        vbl_prev <= vblank_n;
        dma_prev <= dma_done;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pending levels

    always_ff @(posedge clk) begin
        if (reset) begin
            vbl_pending <= 1'b0;
            dma_pending <= 1'b0;
        end else begin
            if (vbl_edge) begin
                vbl_pending <= 1'b1;
            end
            if (dma_edge) begin
                dma_pending <= 1'b1;
            end

            // Acknowledge wins over a new edge in the same clock
            if (iack_access && addr == VBL_LEVEL) begin
                vbl_pending <= 1'b0;
            end
            if (iack_access && addr == DMA_LEVEL) begin
                dma_pending <= 1'b0;
            end
        end
    end

    // Highest level first
    always_ff @(posedge clk) begin
        if (reset) begin
            ipl_n <= 3'b111;
        end else if (dma_pending) begin
            ipl_n <= ~DMA_LEVEL;
        end else if (vbl_pending) begin
            ipl_n <= ~VBL_LEVEL;
        end else begin
            ipl_n <= 3'b111;
        end
    end

endmodule

//--- f2_input_ports.sv
`timescale 1ns/1ps

module f2_input_ports import f2_pkg::*; (
    input  logic             clk,
    input  logic             reset,

    input  logic             access,
    input  logic [IO_AW-1:0] addr,

    input  logic [7:0]       joystick_p1,
    input  logic [7:0]       joystick_p2,
    input  logic [1:0]       start,
    input  logic [1:0]       coin,
    input  logic [7:0]       dswa,
    input  logic [7:0]       dswb,

    output bus_data_t        q
);

    logic [7:0] joy1_s1, joy1_s2;
    logic [7:0] joy2_s1, joy2_s2;
    logic [1:0] start_s1, start_s2;
    logic [1:0] coin_s1, coin_s2;
    logic [7:0] dswa_s1, dswa_s2;
    logic [7:0] dswb_s1, dswb_s2;
    logic [7:0] sel_byte;

    // Two stage synchroniser
    always_ff @(posedge clk) begin
        joy1_s1  <= joystick_p1;
        joy1_s2  <= joy1_s1;
        joy2_s1  <= joystick_p2;
        joy2_s2  <= joy2_s1;
        start_s1 <= start;
        start_s2 <= start_s1;
        coin_s1  <= coin;
        coin_s2  <= coin_s1;
        dswa_s1  <= dswa;
        dswa_s2  <= dswa_s1;
        dswb_s1  <= dswb;
        dswb_s2  <= dswb_s1;
    end

    // Board wiring, direction bits reversed and everything active low
    always_comb begin
        case (addr)
            3'd0: sel_byte = ~dswa_s2;
            3'd1: sel_byte = ~dswb_s2;
            3'd2: sel_byte = ~{start_s2[0], joy1_s2[6:4],
                               joy1_s2[0], joy1_s2[1], joy1_s2[2], joy1_s2[3]};
            3'd3: sel_byte = ~{start_s2[1], joy2_s2[6:4],
                               joy2_s2[0], joy2_s2[1], joy2_s2[2], joy2_s2[3]};
            3'd4: sel_byte = ~{4'b0000, coin_s2, 2'b00};
            default: sel_byte = 8'hFF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (access) begin
            q <= {8'h00, sel_byte};
        end
    end

endmodule

//--- f2_palette.sv
`timescale 1ns/1ps

module f2_palette import f2_pkg::*; (
    input  logic                clk,

    input  logic                access,
    input  logic                rw,
    input  logic [1:0]          ds_n,
    input  logic [COLOR_AW-1:0] addr,
    input  bus_data_t           wdata,
    output bus_data_t           q,

    input  logic [COLOR_AW-1:0] pixel_index,
    output rgb_t                rgb
);

    bus_data_t   mem [2**COLOR_AW];
    logic [14:0] pix_word;
    logic        we_hi;
    logic        we_lo;

    // 5-bit channel to 8 bits by repeating its top bits
    function automatic logic [7:0] widen(input logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    assign we_hi = access && !rw && !ds_n[1];
    assign we_lo = access && !rw && !ds_n[0];

    ////////////////////////////////////////////////////////////////////////////
    // CPU port

    always_ff @(posedge clk) begin
        if (we_hi) begin
            mem[addr][15:8] <= wdata[15:8];
        end
        if (we_lo) begin
            mem[addr][7:0] <= wdata[7:0];
        end
        q <= mem[addr];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pixel port, two stage pipeline

    always_ff @(posedge clk) begin
        pix_word <= mem[pixel_index][14:0];
    end

    // Blue in the top field, red in the bottom
    always_ff @(posedge clk) begin
        rgb.r <= widen(pix_word[4:0]);
        rgb.g <= widen(pix_word[9:5]);
        rgb.b <= widen(pix_word[14:10]);
    end

endmodule

//--- f2_work_ram.sv
`timescale 1ns/1ps

module f2_work_ram import f2_pkg::*; #(
    parameter int ADDR_W_RAM = WORK_AW
) (
    input  logic                  clk,
    input  logic                  access,
    input  logic                  rw,
    input  logic [1:0]            ds_n,
    input  logic [ADDR_W_RAM-1:0] addr,
    input  bus_data_t             wdata,
    output bus_data_t             q
);

    bus_data_t mem [2**ADDR_W_RAM];

    logic we_hi;
    logic we_lo;

    // Upper lane on ds_n[1], lower lane on ds_n[0]
    assign we_hi = access && !rw && !ds_n[1];
    assign we_lo = access && !rw && !ds_n[0];

    always_ff @(posedge clk) begin
        if (we_hi) begin
            mem[addr][15:8] <= wdata[15:8];
        end
        if (we_lo) begin
            mem[addr][7:0] <= wdata[7:0];
        end
        q <= mem[addr];
    end

endmodule

//--- f2_cpu_bus.sv
`timescale 1ns/1ps

module f2_cpu_bus import f2_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    input  logic        as_n,
    input  logic [1:0]  ds_n,
    input  bus_region_t region,

    input  bus_data_t   work_q,
    input  bus_data_t   color_q,
    input  bus_data_t   io_q,

    output logic        work_access,
    output logic        color_access,
    output logic        io_access,
    output logic        iack_access,

    output bus_data_t   rdata,
    output logic        dtack_n
);

    bus_state_t  state;
    bus_region_t region_q;
    logic        strobe_phase;
    logic        cycle_start;
    bus_data_t   read_sel;

    assign cycle_start = !as_n && (ds_n != 2'b11);

    // Unmapped and IACK cycles read as zero
    always_comb begin
        case (region_q)
            REGION_WORK:  read_sel = work_q;
            REGION_COLOR: read_sel = color_q;
            REGION_IO:    read_sel = io_q;
            default:      read_sel = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus cycle sequencer

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= BUS_IDLE;
            region_q     <= REGION_NONE;
            strobe_phase <= 1'b0;
            work_access  <= 1'b0;
            color_access <= 1'b0;
            io_access    <= 1'b0;
            iack_access  <= 1'b0;
            rdata        <= '0;
            dtack_n      <= 1'b1;
        end else begin
            work_access  <= 1'b0;
            color_access <= 1'b0;
            io_access    <= 1'b0;
            iack_access  <= 1'b0;

            case (state)
                BUS_IDLE: begin
                    if (cycle_start) begin
                        state        <= BUS_FETCH;
                        region_q     <= region;
                        strobe_phase <= 1'b1;
                        work_access  <= (region == REGION_WORK);
                        color_access <= (region == REGION_COLOR);
                        io_access    <= (region == REGION_IO);
                        iack_access  <= (region == REGION_IACK);
                    end
                end

                BUS_FETCH: begin
                    // Strobe cycle first, target data is valid one clock later
                    if (strobe_phase) begin
                        strobe_phase <= 1'b0;
                    end else begin
                        rdata   <= read_sel;
                        dtack_n <= 1'b0;
                        state   <= BUS_ACK;
                    end
                end

                BUS_ACK: begin
                    if (as_n) begin
                        dtack_n <= 1'b1;
                        state   <= BUS_IDLE;
                    end
                end

                default: begin
                    state <= BUS_IDLE;
                end
            endcase
        end
    end

endmodule

//--- f2_addr_decode.sv
`timescale 1ns/1ps

module f2_addr_decode import f2_pkg::*; (
    input  word_addr_t  addr,
    input  logic [2:0]  fc,
    output bus_region_t region
);

    logic work_hit;
    logic color_hit;
    logic io_hit;

    // Each region is aligned to its own size, so only the upper bits compare
    assign work_hit  = addr[ADDR_W-1:WORK_AW]  == WORK_BASE[23:WORK_AW+1];
    assign color_hit = addr[ADDR_W-1:COLOR_AW] == COLOR_BASE[23:COLOR_AW+1];
    assign io_hit    = addr[ADDR_W-1:IO_AW]    == IO_BASE[23:IO_AW+1];

    always_comb begin
        if (fc == FC_IACK) begin
            region = REGION_IACK;
        end else if (work_hit) begin
            region = REGION_WORK;
        end else if (color_hit) begin
            region = REGION_COLOR;
        end else if (io_hit) begin
            region = REGION_IO;
        end else begin
            region = REGION_NONE;
        end
    end

endmodule

//--- f2_pkg.sv
package f2_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // CPU bus widths

    // Word address covers byte address bits 23 to 1
    localparam int ADDR_W = 23;
    localparam int DATA_W = 16;

    typedef logic [ADDR_W-1:0] word_addr_t;
    typedef logic [DATA_W-1:0] bus_data_t;

    ////////////////////////////////////////////////////////////////////////////
    // Memory map

    // Work RAM, 64 KB
    localparam logic [23:0] WORK_BASE = 24'h100000;
    localparam int          WORK_AW   = 15;

    // Colour RAM, 4096 entries
    localparam logic [23:0] COLOR_BASE = 24'h200000;
    localparam int          COLOR_AW   = 12;

    // Player inputs and DIP switches
    localparam logic [23:0] IO_BASE = 24'h300000;
    localparam int          IO_AW   = 3;

    ////////////////////////////////////////////////////////////////////////////
    // Interrupts

    localparam logic [2:0] FC_IACK   = 3'b111;
    localparam logic [2:0] VBL_LEVEL = 3'd5;
    localparam logic [2:0] DMA_LEVEL = 3'd6;

    ////////////////////////////////////////////////////////////////////////////
    // Types

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_WORK,
        REGION_COLOR,
        REGION_IO,
        REGION_IACK
    } bus_region_t;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_FETCH,
        BUS_ACK
    } bus_state_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

endpackage
